/* sim/nibu_vectors.txt */
# P imem_word_addr instruction | D dmem_word_addr data | E expected alu result
# E lines follow program order, show carries the low 10 bits, text after the fields is skipped
P 00 06400093 # addi x1, x0, 100
E 00000064
P 01 FF900113 # addi x2, x0, -7
E FFFFFFF9
P 02 3A506193 # ori x3, x0, 0x3a5
E 000003A5
P 03 00208233 # add x4, x1, x2
E 0000005D
P 04 403082B3 # sub x5, x1, x3
E FFFFFCBF
P 05 01C04313 # xori x6, x0, 28
E 0000001C
P 06 0021F3B3 # and x7, x3, x2
E 000003A1
P 07 00112433 # slt x8, x2, x1
E 00000001
P 08 406154B3 # sra x9, x2, x6
E FFFFFFFF
P 09 00615533 # srl x10, x2, x6
E 0000000F
P 0A 008095B3 # sll x11, x1, x8
E 000000C8
P 0B 00126633 # or x12, x4, x1
E 0000007D
P 0C 0032C6B3 # xor x13, x5, x3
E FFFFFF1A
P 0D 0F02F713 # andi x14, x5, 0xf0
E 000000B0
P 0E FFA12793 # slti x15, x2, -6
E 00000001
P 0F 00419813 # slli x16, x3, 4
E 00003A50
P 10 0142D893 # srli x17, x5, 20
E 00000FFF
P 11 40115913 # srai x18, x2, 1
E FFFFFFFC
P 12 04000993 # addi x19, x0, 0x40
E 00000040
P 13 03708013 # addi x0, x1, 55
E 0000009B
P 14 0089AA03 # lw x20, 8(x19)
E 00000048
P 15 00100AB3 # add x21, x0, x1
E 00000064
P 16 001A0B33 # add x22, x20, x1
E 123456DC
D 11 DEADBEEF
D 12 12345678
D 13 CAFEF00D

/* filelist.f */
design/nibu_pkg.sv
design/hex_digit.sv
design/nibu_fetch.sv
design/nibu_decode.sv
design/nibu_regfile.sv
design/nibu_execute.sv
design/nibu.sv
sim/nibu_tb.sv

/* run.sh */
#!/bin/sh
# builds the nibu testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module nibu_tb \
    -f filelist.f -o nibu_sim &&
./obj_dir/nibu_sim || {
    echo "simulation build or run failed"
    exit 1
}

/* sim/nibu_tb.sv */
module nibu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import nibu_pkg::*;

    logic  clk;
    logic  reset;
    load_t load;
    show_t show;
    seg_t  segment7_1;
    seg_t  segment7_2;
    seg_t  segment7_3;
    seg_t  segment7_4;

    word_t  prog_words[$];
    word_t  expected[$];
    load_t  loads[$];
    longint limit_ns = 0;

    nibu u_dut (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .show       (show),
        .segment7_1 (segment7_1),
        .segment7_2 (segment7_2),
        .segment7_3 (segment7_3),
        .segment7_4 (segment7_4)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check(input string name, input word_t exp_val, input word_t act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("Mismatch %s expected 0x%0h actual 0x%0h",
                                name, exp_val, act_val));
        end
    endtask

    // segment bits are gfedcba and lit when high.
    function automatic seg_t seg_of(input nibble_t value);
        case (value)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    task automatic drive_idle();
        load.we   = 1'b0;
        load.dmem = 1'b0;
        load.addr = '0;
        load.data = $urandom;
    endtask

    // the rest of every line is skipped so lines may carry notes.
    task automatic read_vectors();
        int          fd;
        int          code;
        byte         tag;
        logic [31:0] addr;
        word_t       word;
        load_t       entry;
        string       rest;
        fd = $fopen("sim/nibu_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/nibu_vectors.txt");
        end
        code = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            case (tag)
                "#": begin
                end
                "P", "D": begin
                    if ($fscanf(fd, " %h %h", addr, word) != 2) begin
                        abort_run("a memory line in the vectors file is malformed");
                    end
                    entry.we   = 1'b1;
                    entry.dmem = (tag == "D");
                    entry.addr = addr[7:0];
                    entry.data = word;
                    loads.push_back(entry);
                    if (tag == "P") begin
                        if (addr != prog_words.size()) begin
                            abort_run("program words in the vectors file are out of order");
                        end
                        prog_words.push_back(word);
                    end
                end
                "E": begin
                    if ($fscanf(fd, " %h", word) != 1) begin
                        abort_run("an expected value line in the vectors file is malformed");
                    end
                    expected.push_back(word);
                end
                default: begin
                    abort_run($sformatf("unknown line tag %c in the vectors file", tag));
                end
            endcase
            void'($fgets(rest, fd));
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
        if (prog_words.size() == 0 || prog_words.size() != expected.size()) begin
            abort_run("the vectors file needs one expected value per program word");
        end
    endtask

    initial begin
        word_t pc_now;
        word_t word;
        int    prog_len;
        void'($urandom(42200));
        clk   = 1'b0;
        reset = 1'b1;
        drive_idle();
        read_vectors();
        prog_len = prog_words.size();
        limit_ns = (8 + loads.size() + prog_len + 10) * 10;

        repeat (8) begin
            @(negedge clk);
            check("reset show", '0, word_t'(show));
            check("reset pc digit 1", word_t'(seg_of(4'h0)), word_t'(segment7_1));
            check("reset pc digit 2", word_t'(seg_of(4'h0)), word_t'(segment7_2));
            drive_idle();
        end

        // one word per falling edge while reset is still high.
        foreach (loads[i]) begin
            @(negedge clk);
            load = loads[i];
        end

        // an idle cycle in reset must leave the program in place.
        @(negedge clk);
        drive_idle();
        @(negedge clk);
        reset = 1'b0;

        // pass n samples the outputs after rising edge n.
        for (int n = 1; n <= prog_len + 2; n++) begin
            @(negedge clk);
            drive_idle();
            pc_now = 4 * n;
            check($sformatf("pc digit 1 after edge %0d", n),
                  word_t'(seg_of(pc_now[5:2])), word_t'(segment7_1));
            check($sformatf("pc digit 2 after edge %0d", n),
                  word_t'(seg_of(pc_now[9:6])), word_t'(segment7_2));
            if (n <= prog_len) begin
                word = prog_words[n - 1];
                check($sformatf("inst digit 3 of instruction %0d", n - 1),
                      word_t'(seg_of(word[3:0])), word_t'(segment7_3));
                check($sformatf("inst digit 4 of instruction %0d", n - 1),
                      word_t'(seg_of(word[7:4])), word_t'(segment7_4));
            end
            if (n >= 3) begin
                word = expected[n - 3];
                check($sformatf("show of instruction %0d", n - 3),
                      word_t'(word[9:0]), word_t'(show));
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        abort_run("watchdog expired before the program finished");
    end

endmodule

/* design/nibu.sv */
module nibu (
    input  logic            clk,
    input  logic            reset,
    input  nibu_pkg::load_t load,
    output nibu_pkg::show_t show,
    output nibu_pkg::seg_t  segment7_1,
    output nibu_pkg::seg_t  segment7_2,
    output nibu_pkg::seg_t  segment7_3,
    output nibu_pkg::seg_t  segment7_4
);
    import nibu_pkg::*;

    word_t         pc;
    word_t         inst;
    word_t         rs1_data;
    word_t         rs2_data;
    word_t         wdata;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    logic          we;
    dec_ex_t       dec_ex;
    display_t      display;
    nibble_t [3:0] digit_src;
    seg_t    [3:0] digit_seg;

    nibu_fetch u_fetch (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .pc    (pc),
        .inst  (inst)
    );

    nibu_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .inst     (inst),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .dec_ex   (dec_ex)
    );

    nibu_regfile u_regfile (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (wdata),
        .we       (we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    nibu_execute u_execute (
        .clk    (clk),
        .reset  (reset),
        .dec_ex (dec_ex),
        .load   (load),
        .rd     (rd),
        .wdata  (wdata),
        .we     (we),
        .show   (show)
    );

    // inst is the word currently held in decode.
    assign display.pc_lo   = pc[5:2];
    assign display.pc_hi   = pc[9:6];
    assign display.inst_lo = inst[3:0];
    assign display.inst_hi = inst[7:4];
    assign digit_src       = display;

    for (genvar i = 0; i < 4; i++) begin : g_digit
        hex_digit u_digit (
            .nibble   (digit_src[i]),
            .segments (digit_seg[i])
        );
    end

    assign segment7_1 = digit_seg[0];
    assign segment7_2 = digit_seg[1];
    assign segment7_3 = digit_seg[2];
    assign segment7_4 = digit_seg[3];

endmodule

/* design/nibu_execute.sv */
module nibu_execute (
    input  logic               clk,
    input  logic               reset,
    input  nibu_pkg::dec_ex_t  dec_ex,
    input  nibu_pkg::load_t    load,
    output nibu_pkg::reg_idx_t rd,
    output nibu_pkg::word_t    wdata,
    output logic               we,
    output nibu_pkg::show_t    show
);
    import nibu_pkg::*;

    word_t     operand_b;
    word_t     alu_res;
    word_t     dmem_rdata;
    mem_addr_t dmem_addr;
    ex_wb_t    ex_wb;
    word_t     dmem [dmem_words];

    assign operand_b = dec_ex.use_imm ? dec_ex.imm : dec_ex.src2;

    // shifts use only the low five bits of the operand.
    always_comb begin
        case (dec_ex.alu_op)
            alu_add: alu_res = dec_ex.src1 + operand_b;
            alu_sub: alu_res = dec_ex.src1 - operand_b;
            alu_and: alu_res = dec_ex.src1 & operand_b;
            alu_or:  alu_res = dec_ex.src1 | operand_b;
            alu_xor: alu_res = dec_ex.src1 ^ operand_b;
            alu_slt: alu_res = {31'b0, $signed(dec_ex.src1) < $signed(operand_b)};
            alu_sll: alu_res = dec_ex.src1 << operand_b[4:0];
            alu_srl: alu_res = dec_ex.src1 >> operand_b[4:0];
            alu_sra: alu_res = word_t'($signed(dec_ex.src1) >>> operand_b[4:0]);
            default: alu_res = '0;
        endcase
    end

    assign dmem_addr = alu_res[9:2];

    // read-only while running, filled from the load port in reset.
    always_ff @(posedge clk) begin
        if (reset && load.we && load.dmem) begin
            dmem[load.addr] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        dmem_rdata <= dmem[dmem_addr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wb <= '0;
        end else begin
            ex_wb.result     <= alu_res;
            ex_wb.rd         <= dec_ex.rd;
            ex_wb.reg_write  <= dec_ex.reg_write;
            ex_wb.mem_to_reg <= dec_ex.mem_to_reg;
        end
    end

    // writeback, a load returns the memory word but show keeps the address.
    assign rd    = ex_wb.rd;
    assign we    = ex_wb.reg_write;
    assign wdata = ex_wb.mem_to_reg ? dmem_rdata : ex_wb.result;
    assign show  = ex_wb.result[9:0];

endmodule

/* design/nibu_regfile.sv */
module nibu_regfile (
    input  logic               clk,
    input  nibu_pkg::reg_idx_t rs1,
    input  nibu_pkg::reg_idx_t rs2,
    input  nibu_pkg::reg_idx_t rd,
    input  nibu_pkg::word_t    wdata,
    input  logic               we,
    output nibu_pkg::word_t    rs1_data,
    output nibu_pkg::word_t    rs2_data
);
    import nibu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through lets decode see a result two instructions back.
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (we && rs1 == rd) begin
            rs1_data = wdata;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (we && rs2 == rd) begin
            rs2_data = wdata;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

/* design/nibu_decode.sv */
module nibu_decode (
    input  logic               clk,
    input  logic               reset,
    input  nibu_pkg::word_t    inst,
    input  nibu_pkg::word_t    rs1_data,
    input  nibu_pkg::word_t    rs2_data,
    output nibu_pkg::reg_idx_t rs1,
    output nibu_pkg::reg_idx_t rs2,
    output nibu_pkg::dec_ex_t  dec_ex
);
    import nibu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    logic       reg_write;
    logic       use_imm;
    logic       mem_to_reg;
    logic       op_ok;
    logic       inst_valid;
    alu_op_t    alu_op;
    word_t      imm;
    dec_ex_t    dec_next;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign imm      = {{20{inst[31]}}, inst[31:20]};

    always_comb begin
        reg_write  = 1'b0;
        use_imm    = 1'b0;
        mem_to_reg = 1'b0;
        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
            end
            op_imm: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            op_load: begin
                reg_write  = 1'b1;
                use_imm    = 1'b1;
                mem_to_reg = 1'b1;
            end
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

    // lw always adds; immediates never pick sub but shifts keep bit 30.
    always_comb begin
        op_ok  = 1'b1;
        alu_op = alu_add;
        if (opcode != op_load) begin
            case (funct3)
                3'b000:  alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                default: op_ok  = 1'b0;
            endcase
        end
    end

    always_comb begin
        dec_next.src1       = rs1_data;
        dec_next.src2       = rs2_data;
        dec_next.imm        = imm;
        dec_next.use_imm    = use_imm;
        dec_next.alu_op     = alu_op;
        dec_next.rd         = inst[11:7];
        dec_next.reg_write  = reg_write && op_ok && inst_valid;
        dec_next.mem_to_reg = mem_to_reg && inst_valid;
    end

    // the word fetched during reset is not an instruction to run.
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
            dec_ex     <= '0;
        end else begin
            inst_valid <= 1'b1;
            dec_ex     <= dec_next;
        end
    end

    known_alu_op: assert property (
        @(posedge clk) disable iff (reset)
        dec_ex.reg_write |-> !$isunknown(dec_ex.alu_op)
    ) else $error("writing instruction with unknown alu op");

endmodule

/* design/nibu_fetch.sv */
module nibu_fetch (
    input  logic            clk,
    input  logic            reset,
    input  nibu_pkg::load_t load,
    output nibu_pkg::word_t pc,
    output nibu_pkg::word_t inst
);
    import nibu_pkg::*;

    word_t     imem [imem_words];
    mem_addr_t rd_addr;

    assign rd_addr = pc[9:2];

    // no branches, the pc only ever steps one word.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // program is loaded only while the core is held in reset.
    always_ff @(posedge clk) begin
        if (reset && load.we && !load.dmem) begin
            imem[load.addr] <= load.data;
        end
    end

    // synchronous read, inst belongs to the pc of the previous edge.
    always_ff @(posedge clk) begin
        inst <= imem[rd_addr];
    end

    // loading a running core would change code already in flight.
    load_only_in_reset: assert property (
        @(posedge clk) load.we |-> reset
    ) else $error("load strobe seen with reset low");

endmodule

/* design/hex_digit.sv */
module hex_digit (
    input  nibu_pkg::nibble_t nibble,
    output nibu_pkg::seg_t    segments
);

    // patterns are gfedcba, lit when high.
    always_comb begin
        case (nibble)
            4'h0: segments = 7'h3f;
            4'h1: segments = 7'h06;
            4'h2: segments = 7'h5b;
            4'h3: segments = 7'h4f;
            4'h4: segments = 7'h66;
            4'h5: segments = 7'h6d;
            4'h6: segments = 7'h7d;
            4'h7: segments = 7'h07;
            4'h8: segments = 7'h7f;
            4'h9: segments = 7'h6f;
            4'ha: segments = 7'h77;
            4'hb: segments = 7'h7c;
            4'hc: segments = 7'h39;
            4'hd: segments = 7'h5e;
            4'he: segments = 7'h79;
            default: segments = 7'h71;
        endcase
    end

endmodule

/* design/nibu_pkg.sv */
package nibu_pkg;

    // data path widths.
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [9:0]  show_t;
    typedef logic [3:0]  nibble_t;

    // segments run g down to a, lit when high.
    typedef logic [6:0]  seg_t;

    // memory sizes, both memories are word addressed.
    localparam int imem_words = 256;
    localparam int dmem_words = 256;
    typedef logic [7:0] mem_addr_t;

    // supported major opcodes.
    localparam logic [6:0] op_reg  = 7'b0110011;
    localparam logic [6:0] op_imm  = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // dmem set targets the data memory, clear the instruction memory.
    typedef struct packed {
        logic      we;
        logic      dmem;
        mem_addr_t addr;
        word_t     data;
    } load_t;

    typedef struct packed {
        word_t    src1;
        word_t    src2;
        word_t    imm;
        logic     use_imm;
        alu_op_t  alu_op;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
    } dec_ex_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
    } ex_wb_t;

    // pc_lo sits in the low bits so it is digit 0.
    typedef struct packed {
        nibble_t inst_hi;
        nibble_t inst_lo;
        nibble_t pc_hi;
        nibble_t pc_lo;
    } display_t;

endpackage
